/* hw/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // architectural register index
    localparam int reg_name_w = 5;

    // rob tag field, caps the buffer at 32 entries
    localparam int tag_w = 5;

    // op classes the rob tells apart
    // loads retire like alu ops, stores go to the store buffer,
    // branches and jumps may redirect fetch
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_load   = 3'd1,
        op_store  = 3'd2,
        op_branch = 3'd3,
        op_jump   = 3'd4
    } op_e;

endpackage

/* hw/rob_pkg.sv */
package rob_pkg;

    // request from dispatch
    typedef struct packed {
        logic [cpu_cfg_pkg::reg_name_w-1:0] rd;
        cpu_cfg_pkg::op_e                   op;
        logic                               pred_taken;
        logic [cpu_cfg_pkg::xlen-1:0]       pc;
    } alloc_req_t;

    // completion from an execution unit
    typedef struct packed {
        logic [cpu_cfg_pkg::tag_w-1:0] tag;
        logic [cpu_cfg_pkg::xlen-1:0]  data;
        logic                          taken;
        logic [cpu_cfg_pkg::xlen-1:0]  target;
    } wb_t;

    // register file write
    typedef struct packed {
        logic [cpu_cfg_pkg::reg_name_w-1:0] rd;
        logic [cpu_cfg_pkg::xlen-1:0]       data;
        logic [cpu_cfg_pkg::tag_w-1:0]      tag;
    } commit_t;

    typedef struct packed {
        logic [cpu_cfg_pkg::tag_w-1:0] tag;
    } store_rel_t;

    typedef struct packed {
        logic [cpu_cfg_pkg::xlen-1:0] target;
    } redirect_t;

    // head entry as seen by the commit unit
    typedef struct packed {
        logic                               valid;
        logic                               complete;
        logic                               is_store;
        logic                               mispredicted;
        logic [cpu_cfg_pkg::reg_name_w-1:0] rd;
        logic [cpu_cfg_pkg::xlen-1:0]       data;
        logic [cpu_cfg_pkg::xlen-1:0]       target;
    } head_view_t;

    typedef enum logic {
        idle   = 1'b0,
        retire = 1'b1
    } commit_state_e;

endpackage

/* hw/rob_alloc.sv */
module rob_alloc #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          alloc_valid,
    input  rob_pkg::alloc_req_t           alloc_req,
    output logic                          alloc_ready,
    output logic [cpu_cfg_pkg::tag_w-1:0] alloc_tag,
    output logic                          wr_en,
    output logic [cpu_cfg_pkg::tag_w-1:0] wr_tag,
    output rob_pkg::alloc_req_t           wr_req,
    input  logic                          retire,
    input  logic                          flush
);

    localparam int idx_w = $clog2(ROB_DEPTH);
    localparam int cnt_w = idx_w + 1;

    logic [idx_w-1:0] tail_q;
    logic [cnt_w-1:0] count_q;
    logic             full;
    logic             fire;

    assign full        = (count_q == cnt_w'(ROB_DEPTH));
    assign alloc_ready = !full && !flush;
    assign fire        = alloc_valid && alloc_ready;

    // tag is simply the tail slot
    assign alloc_tag = cpu_cfg_pkg::tag_w'(tail_q);

    assign wr_en  = fire;
    assign wr_tag = alloc_tag;
    assign wr_req = alloc_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (fire) begin
                tail_q <= tail_q + 1'b1;
            end
            // allocate and retire may land on the same edge
            case ({fire, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* hw/rob_entry_array.sv */
module rob_entry_array #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          wr_en,
    input  logic [cpu_cfg_pkg::tag_w-1:0] wr_tag,
    input  rob_pkg::alloc_req_t           wr_req,
    input  logic                          wb_valid,
    input  rob_pkg::wb_t                  wb,
    input  logic [cpu_cfg_pkg::tag_w-1:0] head_idx,
    output rob_pkg::head_view_t           head,
    input  logic                          retire,
    input  logic                          flush
);

    localparam int idx_w = $clog2(ROB_DEPTH);

    // per-entry control state
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] complete_q;

    // per-entry payload
    logic                               is_store_q [ROB_DEPTH];
    logic                               is_ctrl_q  [ROB_DEPTH];
    logic                               pred_q     [ROB_DEPTH];
    logic                               act_q      [ROB_DEPTH];
    logic [cpu_cfg_pkg::reg_name_w-1:0] rd_q       [ROB_DEPTH];
    logic [cpu_cfg_pkg::xlen-1:0]       data_q     [ROB_DEPTH];
    logic [cpu_cfg_pkg::xlen-1:0]       target_q   [ROB_DEPTH];

    logic [idx_w-1:0] wr_i;
    logic [idx_w-1:0] wb_i;
    logic [idx_w-1:0] head_i;
    logic             wr_is_store;
    logic             wr_is_ctrl;
    logic             wb_hit;

    assign wr_i   = wr_tag[idx_w-1:0];
    assign wb_i   = wb.tag[idx_w-1:0];
    assign head_i = head_idx[idx_w-1:0];

    // op decode at allocation
    assign wr_is_store = (wr_req.op == cpu_cfg_pkg::op_store);
    assign wr_is_ctrl  = (wr_req.op == cpu_cfg_pkg::op_branch) ||
                         (wr_req.op == cpu_cfg_pkg::op_jump);

    // stale or duplicate completions are dropped
    assign wb_hit = wb_valid && valid_q[wb_i] && !complete_q[wb_i];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= '0;
            complete_q <= '0;
        end else if (flush) begin
            valid_q    <= '0;
            complete_q <= '0;
        end else begin
            if (retire) begin
                valid_q[head_i]    <= 1'b0;
                complete_q[head_i] <= 1'b0;
            end
            if (wr_en) begin
                valid_q[wr_i]    <= 1'b1;
                // stores need no writeback
                complete_q[wr_i] <= wr_is_store;
            end
            if (wb_hit) begin
                complete_q[wb_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            is_store_q[wr_i] <= wr_is_store;
            is_ctrl_q[wr_i]  <= wr_is_ctrl;
            pred_q[wr_i]     <= wr_req.pred_taken;
            rd_q[wr_i]       <= wr_req.rd;
        end
        if (wb_hit) begin
            act_q[wb_i]    <= wb.taken;
            data_q[wb_i]   <= wb.data;
            target_q[wb_i] <= wb.target;
        end
    end

    assign head.valid        = valid_q[head_i];
    assign head.complete     = complete_q[head_i];
    assign head.is_store     = is_store_q[head_i];
    // only branches and jumps can mispredict
    assign head.mispredicted = is_ctrl_q[head_i] && (pred_q[head_i] != act_q[head_i]);
    assign head.rd           = rd_q[head_i];
    assign head.data         = data_q[head_i];
    assign head.target       = target_q[head_i];

endmodule

/* hw/rob_commit.sv */
module rob_commit #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  rob_pkg::head_view_t           head,
    output logic [cpu_cfg_pkg::tag_w-1:0] head_idx,
    output logic                          commit_valid,
    input  logic                          commit_ready,
    output rob_pkg::commit_t              commit,
    output logic                          store_valid,
    input  logic                          store_ready,
    output rob_pkg::store_rel_t           store_rel,
    output logic                          redirect_valid,
    output rob_pkg::redirect_t            redirect,
    output logic                          retire,
    output logic                          flush
);

    localparam int idx_w = $clog2(ROB_DEPTH);

    logic [idx_w-1:0]       head_q;
    rob_pkg::commit_state_e state;
    logic                   commit_fire;
    logic                   store_fire;

    assign head_idx = cpu_cfg_pkg::tag_w'(head_q);

    // head is ready to leave once it is valid and complete
    assign state = (head.valid && head.complete) ? rob_pkg::retire : rob_pkg::idle;

    // steer by entry kind
    assign commit_valid = (state == rob_pkg::retire) && !head.is_store;
    assign store_valid  = (state == rob_pkg::retire) && head.is_store;

    assign commit.rd   = head.rd;
    assign commit.data = head.data;
    assign commit.tag  = head_idx;

    assign store_rel.tag = head_idx;

    assign commit_fire = commit_valid && commit_ready;
    assign store_fire  = store_valid && store_ready;
    assign retire      = commit_fire || store_fire;

    // a mispredicted head redirects fetch and squashes everything younger
    assign flush           = commit_fire && head.mispredicted;
    assign redirect_valid  = flush;
    assign redirect.target = head.target;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q <= '0;
        end else if (flush) begin
            head_q <= '0;
        end else if (retire) begin
            head_q <= head_q + 1'b1;
        end
    end

endmodule

/* hw/rob_top.sv */
module rob_top #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          arst_n,
    // dispatch
    input  logic                          alloc_valid,
    input  rob_pkg::alloc_req_t           alloc_req,
    output logic                          alloc_ready,
    output logic [cpu_cfg_pkg::tag_w-1:0] alloc_tag,
    // writeback
    input  logic                          wb_valid,
    input  rob_pkg::wb_t                  wb,
    // register file
    output logic                          commit_valid,
    input  logic                          commit_ready,
    output rob_pkg::commit_t              commit,
    // store buffer
    output logic                          store_valid,
    input  logic                          store_ready,
    output rob_pkg::store_rel_t           store_rel,
    // fetch
    output logic                          redirect_valid,
    output rob_pkg::redirect_t            redirect
);

    logic                          wr_en;
    logic [cpu_cfg_pkg::tag_w-1:0] wr_tag;
    rob_pkg::alloc_req_t           wr_req;
    logic [cpu_cfg_pkg::tag_w-1:0] head_idx;
    rob_pkg::head_view_t           head;
    logic                          retire;
    logic                          flush;

    rob_alloc #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_alloc (
        .clk        (clk),
        .arst_n     (arst_n),
        .alloc_valid(alloc_valid),
        .alloc_req  (alloc_req),
        .alloc_ready(alloc_ready),
        .alloc_tag  (alloc_tag),
        .wr_en      (wr_en),
        .wr_tag     (wr_tag),
        .wr_req     (wr_req),
        .retire     (retire),
        .flush      (flush)
    );

    rob_entry_array #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_array (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .wr_tag  (wr_tag),
        .wr_req  (wr_req),
        .wb_valid(wb_valid),
        .wb      (wb),
        .head_idx(head_idx),
        .head    (head),
        .retire  (retire),
        .flush   (flush)
    );

    rob_commit #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_commit (
        .clk           (clk),
        .arst_n        (arst_n),
        .head          (head),
        .head_idx      (head_idx),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit),
        .store_valid   (store_valid),
        .store_ready   (store_ready),
        .store_rel     (store_rel),
        .redirect_valid(redirect_valid),
        .redirect      (redirect),
        .retire        (retire),
        .flush         (flush)
    );

endmodule

/* verification/rob_checker.sv */
module rob_checker (
    input logic                clk,
    input logic                arst_n,
    input logic                alloc_ready,
    input logic                commit_valid,
    input logic                commit_ready,
    input rob_pkg::commit_t    commit,
    input logic                store_valid,
    input logic                store_ready,
    input rob_pkg::store_rel_t store_rel,
    input logic                redirect_valid,
    input logic                flush
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int fail_count = 0;

    a_commit_hold: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin
            $error("commit dropped or changed before commit_ready");
            fail_count++;
        end

    // a stalled store buffer sees the same release until it takes it
    a_store_hold: assert property (@(posedge clk) disable iff (!arst_n)
        store_valid && !store_ready |=> store_valid && $stable(store_rel))
        else begin
            $error("store release dropped or changed before store_ready");
            fail_count++;
        end

    // nothing younger than a redirecting branch may retire
    a_redirect_squash: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |=> !commit_valid && !store_valid)
        else begin
            $error("entry retired in the cycle after a redirect");
            fail_count++;
        end

    a_flush_empties: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> alloc_ready)
        else begin
            $error("alloc_ready still low after a flush");
            fail_count++;
        end

endmodule

bind rob_top rob_checker u_checker (
    .clk           (clk),
    .arst_n        (arst_n),
    .alloc_ready   (alloc_ready),
    .commit_valid  (commit_valid),
    .commit_ready  (commit_ready),
    .commit        (commit),
    .store_valid   (store_valid),
    .store_ready   (store_ready),
    .store_rel     (store_rel),
    .redirect_valid(redirect_valid),
    .flush         (flush)
);

/* verification/rob_tb.sv */
module rob_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int depth = 8;
    // six tests at under 300 cycles each, plus margin
    localparam int max_cycles = 2000;

    typedef logic [cpu_cfg_pkg::tag_w-1:0] tag_t;
    typedef logic [cpu_cfg_pkg::xlen-1:0]  word_t;

    // one expected retirement, kept in program order
    typedef struct packed {
        logic             is_store;
        rob_pkg::commit_t c;
    } retire_t;

    logic                clk;
    logic                arst_n;
    logic                alloc_valid;
    rob_pkg::alloc_req_t alloc_req;
    logic                alloc_ready;
    tag_t                alloc_tag;
    logic                wb_valid;
    rob_pkg::wb_t        wb;
    logic                commit_valid;
    logic                commit_ready;
    rob_pkg::commit_t    commit;
    logic                store_valid;
    logic                store_ready;
    rob_pkg::store_rel_t store_rel;
    logic                redirect_valid;
    rob_pkg::redirect_t  redirect;

    retire_t     exp_q[$];
    word_t       pc;
    // model of the tail slot the next dispatch should get
    tag_t        next_tag;
    int          errors;
    int          mark;
    int          tests_run;
    int          tests_failed;
    int          cycles = 0;

    rob_top #(
        .ROB_DEPTH(depth)
    ) u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .alloc_valid   (alloc_valid),
        .alloc_req     (alloc_req),
        .alloc_ready   (alloc_ready),
        .alloc_tag     (alloc_tag),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit),
        .store_valid   (store_valid),
        .store_ready   (store_ready),
        .store_rel     (store_rel),
        .redirect_valid(redirect_valid),
        .redirect      (redirect)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_commit(input rob_pkg::commit_t got, input rob_pkg::commit_t exp);
        if (got !== exp) begin
            $display("[FAIL] commit: got rd=%h data=%h tag=%h, expected rd=%h data=%h tag=%h",
                     got.rd, got.data, got.tag, exp.rd, exp.data, exp.tag);
            errors++;
        end
    endtask

    task automatic compare_store(input rob_pkg::store_rel_t got, input rob_pkg::store_rel_t exp);
        if (got !== exp) begin
            $display("[FAIL] store_rel: got tag=%h, expected tag=%h", got.tag, exp.tag);
            errors++;
        end
    endtask

    task automatic compare_redirect(input rob_pkg::redirect_t got, input rob_pkg::redirect_t exp);
        if (got !== exp) begin
            $display("[FAIL] redirect: got target=%h, expected target=%h", got.target, exp.target);
            errors++;
        end
    endtask

    task automatic compare_tag(input tag_t got, input tag_t exp);
        if (got !== exp) begin
            $display("[FAIL] alloc_tag: got %h, expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // all driver tasks start and end 1 ns after a rising edge
    task automatic dispatch(input rob_pkg::alloc_req_t req, output tag_t tag);
        alloc_valid = 1'b1;
        alloc_req   = req;
        @(negedge clk);
        while (!alloc_ready) begin
            @(negedge clk);
        end
        tag = alloc_tag;
        @(posedge clk);
        #1;
        alloc_valid = 1'b0;
    endtask

    task automatic writeback(input tag_t tag, input word_t data, input logic taken,
                             input word_t target);
        wb_valid  = 1'b1;
        wb.tag    = tag;
        wb.data   = data;
        wb.taken  = taken;
        wb.target = target;
        @(posedge clk);
        #1;
        wb_valid = 1'b0;
    endtask

    task automatic expect_commit(input rob_pkg::commit_t exp);
        commit_ready = 1'b1;
        @(negedge clk);
        while (!commit_valid) begin
            @(negedge clk);
        end
        compare_commit(commit, exp);
        compare_flag("redirect_valid", redirect_valid, 1'b0);
        @(posedge clk);
        #1;
        commit_ready = 1'b0;
    endtask

    task automatic expect_redirect(input rob_pkg::commit_t exp_c, input rob_pkg::redirect_t exp);
        commit_ready = 1'b1;
        @(negedge clk);
        while (!commit_valid) begin
            @(negedge clk);
        end
        compare_commit(commit, exp_c);
        compare_flag("redirect_valid", redirect_valid, 1'b1);
        compare_redirect(redirect, exp);
        @(posedge clk);
        #1;
        commit_ready = 1'b0;
    endtask

    task automatic expect_store(input rob_pkg::store_rel_t exp);
        store_ready = 1'b1;
        @(negedge clk);
        while (!store_valid) begin
            @(negedge clk);
        end
        compare_store(store_rel, exp);
        @(posedge clk);
        #1;
        store_ready = 1'b0;
    endtask

    // dispatch one op and queue what it should retire as
    task automatic issue(input cpu_cfg_pkg::op_e op, input logic [4:0] rd, input logic pred,
                         output tag_t tag, output word_t data);
        rob_pkg::alloc_req_t req;
        retire_t             r;
        req.rd         = rd;
        req.op         = op;
        req.pred_taken = pred;
        req.pc         = pc;
        pc             = pc + 32'd4;
        dispatch(req, tag);
        data       = $urandom;
        r.is_store = (op == cpu_cfg_pkg::op_store);
        r.c.rd     = rd;
        r.c.data   = data;
        r.c.tag    = next_tag;
        next_tag   = tag_t'((next_tag + 1) % depth);
        exp_q.push_back(r);
    endtask

    task automatic drain();
        retire_t             r;
        rob_pkg::store_rel_t s;
        while (exp_q.size() > 0) begin
            r = exp_q.pop_front();
            if (r.is_store) begin
                s.tag = r.c.tag;
                expect_store(s);
            end else begin
                expect_commit(r.c);
            end
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == mark) begin
            $display("%-30s ok", name);
        end else begin
            $display("%-30s failed with %0d errors", name, errors - mark);
            tests_failed++;
        end
        mark = errors;
    endtask

    task automatic reset_and_tags();
        tag_t  t;
        word_t d [3];
        tag_t  tags [3];
        compare_flag("alloc_ready", alloc_ready, 1'b1);
        compare_flag("commit_valid", commit_valid, 1'b0);
        compare_flag("store_valid", store_valid, 1'b0);
        compare_flag("redirect_valid", redirect_valid, 1'b0);
        for (int i = 0; i < 3; i++) begin
            issue(cpu_cfg_pkg::op_alu, 5'(i + 1), 1'b0, t, d[i]);
            tags[i] = t;
            compare_tag(t, tag_t'(i));
        end
        for (int i = 0; i < 3; i++) begin
            writeback(tags[i], d[i], 1'b0, '0);
        end
        drain();
        report_test("reset state and tag order");
    endtask

    task automatic out_of_order_writeback();
        tag_t  t [4];
        word_t d [4];
        for (int i = 0; i < 4; i++) begin
            issue(cpu_cfg_pkg::op_alu, 5'(i + 5), 1'b0, t[i], d[i]);
        end
        for (int i = 3; i >= 0; i--) begin
            writeback(t[i], d[i], 1'b0, '0);
        end
        drain();
        report_test("reverse writeback order");
    endtask

    task automatic full_and_backpressure();
        tag_t  t [depth];
        word_t d [depth];
        for (int i = 0; i < depth; i++) begin
            issue(cpu_cfg_pkg::op_load, 5'(i + 1), 1'b0, t[i], d[i]);
        end
        @(negedge clk);
        compare_flag("alloc_ready", alloc_ready, 1'b0);
        @(posedge clk);
        #1;
        for (int i = 0; i < depth; i++) begin
            writeback(t[i], d[i], 1'b0, '0);
        end
        // head must hold while the register file stalls
        repeat (3) begin
            @(negedge clk);
            compare_flag("commit_valid", commit_valid, 1'b1);
            compare_commit(commit, exp_q[0].c);
        end
        @(posedge clk);
        #1;
        drain();
        @(negedge clk);
        compare_flag("alloc_ready", alloc_ready, 1'b1);
        @(posedge clk);
        #1;
        report_test("full rob and back-pressure");
    endtask

    task automatic store_in_order();
        tag_t    t [3];
        word_t   d [3];
        retire_t r;
        issue(cpu_cfg_pkg::op_alu, 5'd7, 1'b0, t[0], d[0]);
        issue(cpu_cfg_pkg::op_store, 5'd0, 1'b0, t[1], d[1]);
        issue(cpu_cfg_pkg::op_alu, 5'd8, 1'b0, t[2], d[2]);
        // the store gets no writeback
        writeback(t[2], d[2], 1'b0, '0);
        writeback(t[0], d[0], 1'b0, '0);
        r = exp_q.pop_front();
        expect_commit(r.c);
        // store sits at the head while the store buffer stalls
        repeat (2) @(posedge clk);
        #1;
        drain();
        report_test("store release in order");
    endtask

    task automatic mispredict_flush();
        tag_t               t [4];
        word_t              d [4];
        retire_t            r;
        rob_pkg::redirect_t exp_redir;
        tag_t               t_new;
        word_t              d_new;
        issue(cpu_cfg_pkg::op_alu, 5'd10, 1'b0, t[0], d[0]);
        issue(cpu_cfg_pkg::op_branch, 5'd11, 1'b0, t[1], d[1]);
        issue(cpu_cfg_pkg::op_alu, 5'd12, 1'b0, t[2], d[2]);
        issue(cpu_cfg_pkg::op_alu, 5'd13, 1'b0, t[3], d[3]);
        writeback(t[3], d[3], 1'b0, '0);
        writeback(t[2], d[2], 1'b0, '0);
        writeback(t[0], d[0], 1'b0, '0);
        writeback(t[1], d[1], 1'b1, 32'h0000_4000);
        r = exp_q.pop_front();
        expect_commit(r.c);
        r = exp_q.pop_front();
        exp_redir.target = 32'h0000_4000;
        expect_redirect(r.c, exp_redir);
        exp_q.delete();
        // flush sends the tail back to slot 0
        next_tag = '0;
        // younger entries were squashed
        commit_ready = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (commit_valid) begin
                $display("squashed entry with tag %h reached the commit port", commit.tag);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        commit_ready = 1'b0;
        issue(cpu_cfg_pkg::op_alu, 5'd14, 1'b0, t_new, d_new);
        compare_tag(t_new, '0);
        writeback(t_new, d_new, 1'b0, '0);
        drain();
        report_test("mispredict redirect and flush");
    endtask

    task automatic correct_branch();
        tag_t  t [3];
        word_t d [3];
        issue(cpu_cfg_pkg::op_branch, 5'd20, 1'b1, t[0], d[0]);
        issue(cpu_cfg_pkg::op_alu, 5'd21, 1'b0, t[1], d[1]);
        issue(cpu_cfg_pkg::op_jump, 5'd22, 1'b1, t[2], d[2]);
        writeback(t[1], d[1], 1'b0, '0);
        writeback(t[0], d[0], 1'b1, 32'h0000_2000);
        writeback(t[2], d[2], 1'b1, 32'h0000_3000);
        drain();
        report_test("correctly predicted branch");
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        alloc_valid  = 1'b0;
        alloc_req    = '0;
        wb_valid     = 1'b0;
        wb           = '0;
        commit_ready = 1'b0;
        store_ready  = 1'b0;
        errors       = 0;
        mark         = 0;
        tests_run    = 0;
        tests_failed = 0;
        pc           = 32'h0000_1000;
        next_tag     = '0;
        void'($urandom(32'h0c14b0db));
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        reset_and_tags();
        out_of_order_writeback();
        full_and_backpressure();
        store_in_order();
        mispredict_flush();
        correct_branch();
        if (u_dut.u_checker.fail_count != 0) begin
            $display("bound assertions failed %0d times", u_dut.u_checker.fail_count);
            errors += u_dut.u_checker.fail_count;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/cpu_cfg_pkg.sv
hw/rob_pkg.sv
hw/rob_alloc.sv
hw/rob_entry_array.sv
hw/rob_commit.sv
hw/rob_top.sv
verification/rob_checker.sv
verification/rob_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
